/* src.f */
src/corePkg.sv
src/registerFile.sv
src/decodeStage.sv
src/operandStage.sv
src/executeStage.sv
src/intPipeline.sv
verification/pipelineTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing -j 0
TOP = pipelineTb
FILELIST = src.f
BUILD_DIR = obj_dir
PASS_TEXT = Done: no errors

SIM = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* verification/pipelineTb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipelineTb;

    localparam int randomCount = 300;
    localparam int directedCount = 26;
    // Ten cycles per instruction plus margin for reset and drains
    localparam int timeoutCycles = (randomCount + directedCount) * 10 + 500;

    typedef struct packed {
        corePkg::retireInfo info;
        int acceptCycle;
        int latency;
    } expectEntry;

    logic clk;
    logic reset;
    logic instrValid;
    corePkg::instrWord instrData;
    logic instrReady;
    logic retireValid;
    corePkg::retireInfo retireData;

    logic [31:0] modelRegs [32];
    expectEntry expectQ [$];
    int cycle = 0;
    int errorCount = 0;
    int checkCount = 0;
    int testErrors = 0;
    int readyLowCount = 0;

    intPipeline intPipeline_inst (
        .clk(clk),
        .reset(reset),
        .instrValid(instrValid),
        .instrData(instrData),
        .instrReady(instrReady),
        .retireValid(retireValid),
        .retireData(retireData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, expected);
        end
    endtask

    function automatic corePkg::instrWord rInstr(input logic [5:0] func, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [4:0] rd);
        corePkg::instrWord w;
        w.rView.op = corePkg::opRType;
        w.rView.rs = rs;
        w.rView.rt = rt;
        w.rView.rd = rd;
        w.rView.shamt = 5'd0;
        w.rView.func = func;
        return w;
    endfunction

    function automatic corePkg::instrWord iInstr(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        corePkg::instrWord w;
        w.iView.op = op;
        w.iView.rs = rs;
        w.iView.rt = rt;
        w.iView.imm16 = imm;
        return w;
    endfunction

    // ISA model that returns 1 when the instruction writes a register
    function automatic logic modelExec(input corePkg::instrWord w,
                                       output corePkg::retireInfo info);
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        logic [4:0] dest;
        logic [31:0] result;
        a = modelRegs[w.rView.rs];
        b = modelRegs[w.rView.rt];
        imm = w.iView.imm16;
        dest = 5'd0;
        result = 32'd0;
        case (w.rView.op)
            corePkg::opRType: begin
                dest = w.rView.rd;
                case (w.rView.func)
                    corePkg::funcAdd: result = a + b;
                    corePkg::funcSub: result = a - b;
                    corePkg::funcAnd: result = a & b;
                    corePkg::funcOr: result = a | b;
                    corePkg::funcSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    corePkg::funcSltu: result = (a < b) ? 32'd1 : 32'd0;
                    default: dest = 5'd0;
                endcase
            end
            corePkg::opAddi: begin
                dest = w.iView.rt;
                result = a + {{16{imm[15]}}, imm};
            end
            corePkg::opAndi: begin
                dest = w.iView.rt;
                result = a & {16'h0000, imm};
            end
            corePkg::opOri: begin
                dest = w.iView.rt;
                result = a | {16'h0000, imm};
            end
            corePkg::opLui: begin
                dest = w.iView.rt;
                result = {imm, 16'h0000};
            end
            default: dest = 5'd0;
        endcase
        info.destReg = dest;
        info.result = result;
        if (dest == 5'd0) begin
            return 1'b0;
        end
        modelRegs[dest] = result;
        return 1'b1;
    endfunction

    // Small register range so dependences come often
    function automatic corePkg::instrWord randomInstr();
        logic [5:0] funcs [6];
        logic [5:0] ops [4];
        logic [5:0] badOps [5];
        logic [2:0] funcIdx;
        logic [1:0] opIdx;
        logic [2:0] badIdx;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        int kind;
        funcs = '{corePkg::funcAdd, corePkg::funcSub, corePkg::funcAnd,
                  corePkg::funcOr, corePkg::funcSlt, corePkg::funcSltu};
        ops = '{corePkg::opAddi, corePkg::opAndi, corePkg::opOri, corePkg::opLui};
        badOps = '{6'h23, 6'h2b, 6'h04, 6'h02, 6'h1c};
        funcIdx = 3'($urandom % 6);
        opIdx = 2'($urandom % 4);
        badIdx = 3'($urandom % 5);
        rs = 5'($urandom % 8);
        rt = 5'($urandom % 8);
        rd = 5'($urandom % 8);
        kind = int'($urandom % 10);
        if (kind < 5) begin
            return rInstr(funcs[funcIdx], rs, rt, rd);
        end else if (kind < 9) begin
            return iInstr(ops[opIdx], rs, rt, 16'($urandom));
        end
        return iInstr(badOps[badIdx], rs, rt, 16'($urandom));
    endfunction

    // Holds the word until accepted
    task automatic sendInstr(input corePkg::instrWord w, input int latency, input int gap);
        logic accepted;
        int acceptAt;
        corePkg::retireInfo info;
        expectEntry entry;
        instrValid = 1'b1;
        instrData = w;
        accepted = 1'b0;
        acceptAt = 0;
        while (!accepted) begin
            @(negedge clk);
            accepted = instrReady;
            acceptAt = cycle;
            @(posedge clk);
        end
        if (modelExec(w, info)) begin
            entry.info = info;
            entry.acceptCycle = acceptAt;
            entry.latency = latency;
            expectQ.push_back(entry);
        end
        #1;
        instrValid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drainPipeline();
        while (expectQ.size() != 0) begin
            @(posedge clk);
        end
        // A few more cycles to catch stray retire pulses
        repeat (6) @(posedge clk);
        #1;
    endtask

    task automatic finishTest(input string name);
        $display("Test %s finished with %0d errors", name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    always @(negedge clk) begin : compareRetire
        expectEntry head;
        if (!reset && retireValid) begin
            if (expectQ.size() == 0) begin
                errorCount++;
                $display("Retire pulse for register %0d when no write was expected",
                         retireData.destReg);
            end else begin
                head = expectQ.pop_front();
                checkValue("retireData.destReg", 32'(retireData.destReg),
                           32'(head.info.destReg));
                checkValue("retireData.result", retireData.result, head.info.result);
                // Latency 0 means no timing check
                if (head.latency != 0) begin
                    checkValue("retire latency", cycle - head.acceptCycle, head.latency);
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!reset && !instrReady) begin
            readyLowCount++;
        end
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("Timeout after %0d cycles, the pipeline stopped making progress",
                 timeoutCycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int gap;
        corePkg::instrWord w;
        void'($urandom(32'h1c2d8443));
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'd0;
        end
        reset = 1'b1;
        instrValid = 1'b0;
        instrData = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        repeat (5) begin
            @(negedge clk);
            checkValue("instrReady", 32'(instrReady), 32'd1);
            checkValue("retireValid", 32'(retireValid), 32'd0);
        end
        @(posedge clk);
        #1;
        finishTest("reset state");

        // Set up operands and run every ALU op with no stall
        sendInstr(iInstr(corePkg::opLui, 5'd0, 5'd1, 16'h8000), 3, 2);
        sendInstr(iInstr(corePkg::opOri, 5'd0, 5'd2, 16'h1234), 3, 2);
        sendInstr(iInstr(corePkg::opAddi, 5'd0, 5'd3, 16'hfffb), 3, 2);
        sendInstr(iInstr(corePkg::opAndi, 5'd3, 5'd4, 16'hf0f0), 3, 2);
        sendInstr(iInstr(corePkg::opOri, 5'd1, 5'd1, 16'h0001), 3, 2);
        sendInstr(rInstr(corePkg::funcAdd, 5'd1, 5'd2, 5'd5), 3, 2);
        sendInstr(rInstr(corePkg::funcSub, 5'd2, 5'd3, 5'd6), 3, 2);
        sendInstr(rInstr(corePkg::funcAnd, 5'd3, 5'd4, 5'd7), 3, 2);
        sendInstr(rInstr(corePkg::funcOr, 5'd1, 5'd4, 5'd8), 3, 2);
        sendInstr(rInstr(corePkg::funcSlt, 5'd1, 5'd2, 5'd9), 3, 2);
        sendInstr(rInstr(corePkg::funcSltu, 5'd1, 5'd2, 5'd10), 3, 2);
        sendInstr(rInstr(corePkg::funcSlt, 5'd2, 5'd3, 5'd11), 3, 2);
        sendInstr(rInstr(corePkg::funcSltu, 5'd2, 5'd3, 5'd12), 3, 2);
        sendInstr(iInstr(corePkg::opAddi, 5'd2, 5'd13, 16'h8000), 3, 2);
        drainPipeline();
        finishTest("single ALU ops");

        // Middle word depends on the first and stalls once
        readyLowCount = 0;
        sendInstr(iInstr(corePkg::opAddi, 5'd2, 5'd20, 16'h0010), 3, 0);
        sendInstr(rInstr(corePkg::funcAdd, 5'd20, 5'd20, 5'd21), 4, 0);
        sendInstr(rInstr(corePkg::funcOr, 5'd1, 5'd2, 5'd22), 3, 0);
        drainPipeline();
        checkValue("instrReady low cycles", readyLowCount, 32'd1);
        finishTest("back-to-back dependence");

        sendInstr(iInstr(6'h23, 5'd1, 5'd3, 16'h0004), 3, 2);
        sendInstr(iInstr(6'h04, 5'd1, 5'd2, 16'h0008), 3, 2);
        sendInstr(iInstr(6'h02, 5'd4, 5'd5, 16'h0100), 3, 2);
        sendInstr(rInstr(6'h18, 5'd1, 5'd2, 5'd6), 3, 2);
        sendInstr('0, 3, 2);
        sendInstr(rInstr(corePkg::funcAdd, 5'd1, 5'd2, 5'd0), 3, 2);
        sendInstr(iInstr(corePkg::opAddi, 5'd0, 5'd0, 16'h0005), 3, 2);
        sendInstr(rInstr(corePkg::funcOr, 5'd0, 5'd0, 5'd14), 3, 2);
        sendInstr(iInstr(corePkg::opAddi, 5'd0, 5'd15, 16'h0007), 3, 2);
        drainPipeline();
        finishTest("no-write instructions");

        for (int i = 0; i < randomCount; i++) begin
            w = randomInstr();
            gap = ($urandom % 4 == 0) ? int'($urandom % 3) : 0;
            sendInstr(w, 0, gap);
        end
        drainPipeline();
        finishTest("random stream");

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/intPipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module intPipeline (
    input logic clk,
    input logic reset,
    input logic instrValid,
    input corePkg::instrWord instrData,
    output logic instrReady,
    output logic retireValid,
    output corePkg::retireInfo retireData
);

    logic decValid;
    logic decReady;
    corePkg::decodedInstr decInstr;
    logic exValid;
    corePkg::execInstr exInstr;
    logic [corePkg::regAddrBits-1:0] exDest;
    logic [1:0] exTnew;
    logic [corePkg::regAddrBits-1:0] rsAddr;
    logic [corePkg::regAddrBits-1:0] rtAddr;
    logic [corePkg::dataWidth-1:0] rsData;
    logic [corePkg::dataWidth-1:0] rtData;

    decodeStage decodeStage_inst (
        .clk(clk),
        .reset(reset),
        .instrValid(instrValid),
        .instrData(instrData),
        .instrReady(instrReady),
        .decValid(decValid),
        .decInstr(decInstr),
        .decReady(decReady)
    );

    operandStage operandStage_inst (
        .clk(clk),
        .reset(reset),
        .decValid(decValid),
        .decInstr(decInstr),
        .decReady(decReady),
        .rsAddr(rsAddr),
        .rtAddr(rtAddr),
        .rsData(rsData),
        .rtData(rtData),
        .exDest(exDest),
        .exTnew(exTnew),
        .retireValid(retireValid),
        .retireData(retireData),
        .exValid(exValid),
        .exInstr(exInstr)
    );

    // Write port fed from the retire register
    registerFile registerFile_inst (
        .clk(clk),
        .reset(reset),
        .rsAddr(rsAddr),
        .rtAddr(rtAddr),
        .rsData(rsData),
        .rtData(rtData),
        .writeEnable(retireValid),
        .writeAddr(retireData.destReg),
        .writeData(retireData.result)
    );

    executeStage executeStage_inst (
        .clk(clk),
        .reset(reset),
        .exValid(exValid),
        .exInstr(exInstr),
        .exDest(exDest),
        .exTnew(exTnew),
        .retireValid(retireValid),
        .retireData(retireData)
    );

endmodule

`default_nettype wire

/* src/executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input logic clk,
    input logic reset,
    input logic exValid,
    input corePkg::execInstr exInstr,
    output logic [corePkg::regAddrBits-1:0] exDest,
    output logic [1:0] exTnew,
    output logic retireValid,
    output corePkg::retireInfo retireData
);

    corePkg::ctrlWord ctrl;
    logic [corePkg::dataWidth-1:0] immExt;
    logic [corePkg::dataWidth-1:0] srcA;
    logic [corePkg::dataWidth-1:0] srcB;
    logic [corePkg::dataWidth-1:0] aluResult;

    assign ctrl = exInstr.ctrl;

    // Hazard info back to operand stays quiet on a bubble
    assign exDest = exValid ? ctrl.destReg : '0;
    assign exTnew = exValid ? ctrl.tnew : corePkg::tnewNone;

    assign immExt = ctrl.signExtImm ? {{16{exInstr.imm16[15]}}, exInstr.imm16}
                                    : {16'b0, exInstr.imm16};
    assign srcA = exInstr.operandA;
    assign srcB = ctrl.useImm ? immExt : exInstr.operandB;

    always_comb begin
        case (ctrl.aluSel)
            corePkg::aluAdd: aluResult = srcA + srcB;
            corePkg::aluSub: aluResult = srcA - srcB;
            corePkg::aluAnd: aluResult = srcA & srcB;
            corePkg::aluOr: aluResult = srcA | srcB;
            corePkg::aluLui: aluResult = {exInstr.imm16, 16'b0};
            corePkg::aluSlt: aluResult = {31'b0, $signed(srcA) < $signed(srcB)};
            corePkg::aluSltu: aluResult = {31'b0, srcA < srcB};
            default: aluResult = '0;
        endcase
    end

    // Retire register
    always_ff @(posedge clk) begin
        if (reset) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= exValid && (ctrl.destReg != '0);
        end
    end

    always_ff @(posedge clk) begin
        retireData.destReg <= ctrl.destReg;
        retireData.result <= aluResult;
    end

endmodule

`default_nettype wire

/* src/operandStage.sv */
`timescale 1ns/1ps
`default_nettype none

module operandStage (
    input logic clk,
    input logic reset,
    input logic decValid,
    input corePkg::decodedInstr decInstr,
    output logic decReady,
    output logic [corePkg::regAddrBits-1:0] rsAddr,
    output logic [corePkg::regAddrBits-1:0] rtAddr,
    input logic [corePkg::dataWidth-1:0] rsData,
    input logic [corePkg::dataWidth-1:0] rtData,
    input logic [corePkg::regAddrBits-1:0] exDest,
    input logic [1:0] exTnew,
    input logic retireValid,
    input corePkg::retireInfo retireData,
    output logic exValid,
    output corePkg::execInstr exInstr
);

    corePkg::ctrlWord ctrl;
    logic rsHazard;
    logic rtHazard;
    logic stall;
    logic [corePkg::dataWidth-1:0] rsValue;
    logic [corePkg::dataWidth-1:0] rtValue;

    // Retire register wins over the file on an address match
    function automatic logic [corePkg::dataWidth-1:0] forwardSel(
        input logic [corePkg::regAddrBits-1:0] addr,
        input logic [corePkg::dataWidth-1:0] fileData
    );
        logic hit;
        hit = retireValid && (retireData.destReg != '0) && (retireData.destReg == addr);
        return hit ? retireData.result : fileData;
    endfunction

    assign ctrl = decInstr.ctrl;

    assign rsAddr = decInstr.instr.rView.rs;
    assign rtAddr = decInstr.instr.rView.rt;

    // Tuse/Tnew check against the instruction in execute
    assign rsHazard = ctrl.readRs && (exDest != '0) && (rsAddr == exDest)
                      && (exTnew > ctrl.tuseRs);
    assign rtHazard = ctrl.readRt && (exDest != '0) && (rtAddr == exDest)
                      && (exTnew > ctrl.tuseRt);
    assign stall = decValid && (rsHazard || rtHazard);

    assign decReady = !stall;

    always_comb begin
        rsValue = forwardSel(rsAddr, rsData);
        rtValue = forwardSel(rtAddr, rtData);
    end

    // A stall sends a bubble while decode holds its word
    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
        end else begin
            exValid <= decValid && !stall;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            exInstr.ctrl <= ctrl;
            exInstr.operandA <= rsValue;
            exInstr.operandB <= rtValue;
            exInstr.imm16 <= decInstr.instr.iView.imm16;
        end
    end

endmodule

`default_nettype wire

/* src/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input logic clk,
    input logic reset,
    input logic instrValid,
    input corePkg::instrWord instrData,
    output logic instrReady,
    output logic decValid,
    output corePkg::decodedInstr decInstr,
    input logic decReady
);

    logic isRType;
    logic isAdd;
    logic isSub;
    logic isAnd;
    logic isOr;
    logic isSlt;
    logic isSltu;
    logic isAddi;
    logic isAndi;
    logic isOri;
    logic isLui;
    logic isCalR;
    logic isCalI;
    logic loadSlot;
    corePkg::ctrlWord ctrlNext;

    // Instruction recognition
    assign isRType = (instrData.rView.op == corePkg::opRType);
    assign isAdd = isRType && (instrData.rView.func == corePkg::funcAdd);
    assign isSub = isRType && (instrData.rView.func == corePkg::funcSub);
    assign isAnd = isRType && (instrData.rView.func == corePkg::funcAnd);
    assign isOr = isRType && (instrData.rView.func == corePkg::funcOr);
    assign isSlt = isRType && (instrData.rView.func == corePkg::funcSlt);
    assign isSltu = isRType && (instrData.rView.func == corePkg::funcSltu);

    assign isAddi = (instrData.iView.op == corePkg::opAddi);
    assign isAndi = (instrData.iView.op == corePkg::opAndi);
    assign isOri = (instrData.iView.op == corePkg::opOri);
    assign isLui = (instrData.iView.op == corePkg::opLui);

    // Classes
    assign isCalR = isAdd || isSub || isAnd || isOr || isSlt || isSltu;
    assign isCalI = isAddi || isAndi || isOri || isLui;

    always_comb begin
        // Nop and unsupported words leave this as a no-write bubble
        ctrlNext = '0;
        ctrlNext.tuseRs = corePkg::tuseNever;
        ctrlNext.tuseRt = corePkg::tuseNever;
        ctrlNext.tnew = corePkg::tnewNone;

        if (isCalR) begin
            ctrlNext.destReg = instrData.rView.rd;
            ctrlNext.readRs = 1'b1;
            ctrlNext.readRt = 1'b1;
            ctrlNext.tuseRs = corePkg::tuseAlu;
            ctrlNext.tuseRt = corePkg::tuseAlu;
            ctrlNext.tnew = corePkg::tnewAlu;
        end else if (isCalI) begin
            ctrlNext.destReg = instrData.iView.rt;
            ctrlNext.useImm = 1'b1;
            ctrlNext.signExtImm = isAddi;
            // Lui uses only its immediate
            ctrlNext.readRs = !isLui;
            ctrlNext.tuseRs = isLui ? corePkg::tuseNever : corePkg::tuseAlu;
            ctrlNext.tnew = corePkg::tnewAlu;
        end

        // ALU code with add as the fallback
        if (isSub) begin
            ctrlNext.aluSel = corePkg::aluSub;
        end else if (isAnd || isAndi) begin
            ctrlNext.aluSel = corePkg::aluAnd;
        end else if (isOr || isOri) begin
            ctrlNext.aluSel = corePkg::aluOr;
        end else if (isLui) begin
            ctrlNext.aluSel = corePkg::aluLui;
        end else if (isSlt) begin
            ctrlNext.aluSel = corePkg::aluSlt;
        end else if (isSltu) begin
            ctrlNext.aluSel = corePkg::aluSltu;
        end else begin
            ctrlNext.aluSel = corePkg::aluAdd;
        end
    end

    // Slot advances when empty or drained downstream
    assign loadSlot = !decValid || decReady;
    assign instrReady = loadSlot;

    always_ff @(posedge clk) begin
        if (reset) begin
            decValid <= 1'b0;
        end else if (loadSlot) begin
            decValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (loadSlot && instrValid) begin
            decInstr.instr <= instrData;
            decInstr.ctrl <= ctrlNext;
        end
    end

endmodule

`default_nettype wire

/* src/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input logic clk,
    input logic reset,
    input logic [corePkg::regAddrBits-1:0] rsAddr,
    input logic [corePkg::regAddrBits-1:0] rtAddr,
    output logic [corePkg::dataWidth-1:0] rsData,
    output logic [corePkg::dataWidth-1:0] rtData,
    input logic writeEnable,
    input logic [corePkg::regAddrBits-1:0] writeAddr,
    input logic [corePkg::dataWidth-1:0] writeData
);

    logic [corePkg::dataWidth-1:0] regs [corePkg::regCount];

    // Zero register reads zero and a same-cycle write passes straight through
    function automatic logic [corePkg::dataWidth-1:0] readPort(
        input logic [corePkg::regAddrBits-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (writeEnable && (writeAddr == addr)) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < corePkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    always_comb begin
        rsData = readPort(rsAddr);
        rtData = readPort(rtAddr);
    end

endmodule

`default_nettype wire

/* src/corePkg.sv */
`default_nettype none

package corePkg;

    localparam int regCount = 32;
    localparam int dataWidth = 32;
    localparam int regAddrBits = $clog2(regCount);

    // Opcodes of the kept instructions
    localparam logic [5:0] opRType = 6'b000_000;
    localparam logic [5:0] opAddi = 6'b001_000;
    localparam logic [5:0] opAndi = 6'b001_100;
    localparam logic [5:0] opOri = 6'b001_101;
    localparam logic [5:0] opLui = 6'b001_111;

    // R-type function codes
    localparam logic [5:0] funcAdd = 6'b100_000;
    localparam logic [5:0] funcSub = 6'b100_010;
    localparam logic [5:0] funcAnd = 6'b100_100;
    localparam logic [5:0] funcOr = 6'b100_101;
    localparam logic [5:0] funcSlt = 6'b101_010;
    localparam logic [5:0] funcSltu = 6'b101_011;

    // Hazard timing values
    localparam logic [1:0] tuseAlu = 2'd1;
    localparam logic [1:0] tuseNever = 2'd3;
    localparam logic [1:0] tnewAlu = 2'd2;
    localparam logic [1:0] tnewNone = 2'd0;

    typedef struct packed {
        logic [5:0] op;
        logic [regAddrBits-1:0] rs;
        logic [regAddrBits-1:0] rt;
        logic [regAddrBits-1:0] rd;
        logic [4:0] shamt;
        logic [5:0] func;
    } rFormat;

    typedef struct packed {
        logic [5:0] op;
        logic [regAddrBits-1:0] rs;
        logic [regAddrBits-1:0] rt;
        logic [15:0] imm16;
    } iFormat;

    // One word read in R or I format
    typedef union packed {
        rFormat rView;
        iFormat iView;
    } instrWord;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr = 4'd3,
        aluLui = 4'd4,
        aluSlt = 4'd5,
        aluSltu = 4'd6
    } aluOp;

    typedef struct packed {
        logic [regAddrBits-1:0] destReg;
        aluOp aluSel;
        logic useImm;
        logic signExtImm;
        logic readRs;
        logic readRt;
        logic [1:0] tuseRs;
        logic [1:0] tuseRt;
        logic [1:0] tnew;
    } ctrlWord;

    typedef struct packed {
        instrWord instr;
        ctrlWord ctrl;
    } decodedInstr;

    typedef struct packed {
        ctrlWord ctrl;
        logic [dataWidth-1:0] operandA;
        logic [dataWidth-1:0] operandB;
        logic [15:0] imm16;
    } execInstr;

    typedef struct packed {
        logic [regAddrBits-1:0] destReg;
        logic [dataWidth-1:0] result;
    } retireInfo;

endpackage

`default_nettype wire
